// ==== common/l1_cache_pkg.sv ====
// cache geometry localparams, address and frame structs, processor and memory bus structs
package l1_cache_pkg;

    localparam int WORD_W       = 32;
    localparam int BLOCK_SIZE   = 2;       // words per block
    localparam int ASSOC        = 2;
    localparam int N_SETS       = 16;
    localparam int N_SET_BITS   = 4;
    localparam int N_BLOCK_BITS = 1;
    localparam int N_WAY_BITS   = 1;       // way index width
    localparam int N_TAG_BITS   = WORD_W - N_SET_BITS - N_BLOCK_BITS - 2;

    localparam logic [WORD_W-1:0] NONCACHE_START_ADDR = 32'hF000_0000;

    typedef logic [WORD_W-1:0] word_t;
    typedef word_t [BLOCK_SIZE-1:0] block_t;

    // address split, msb first
    typedef struct packed {
        logic [N_TAG_BITS-1:0]   tag;
        logic [N_SET_BITS-1:0]   set_idx;
        logic [N_BLOCK_BITS-1:0] blk_off;
        logic [1:0]              byte_off;
    } cache_addr_t;

    typedef struct packed {
        logic                  valid;
        logic                  dirty;
        logic [N_TAG_BITS-1:0] tag;
    } tag_entry_t;

    // one write to one way, tag and data can go together
    typedef struct packed {
        logic       tag_wen;
        tag_entry_t tag;
        logic       data_wen;
        block_t     data;
        block_t     data_mask;   // a one keeps the old bit
    } way_cmd_t;

    typedef struct packed {
        tag_entry_t tag;
        block_t     data;
    } way_read_t;

    typedef struct packed {
        logic       ren;
        logic       wen;
        word_t      addr;
        word_t      wdata;
        logic [3:0] byte_en;
    } proc_req_t;

    typedef struct packed {
        logic  busy;
        word_t rdata;
    } proc_resp_t;

    typedef struct packed {
        logic       ren;
        logic       wen;
        word_t      addr;
        block_t     wdata;
        logic [3:0] byte_en;     // only meaningful on pass-through
    } mem_req_t;

    // pass-through data comes back in word 0
    typedef struct packed {
        logic   busy;
        block_t rdata;
    } mem_resp_t;

endpackage

// ==== source/sram_array.sv ====
// sram_array: per-set register storage with masked write, payload chosen by type parameter
`timescale 1ns/1ps

module sram_array #(
    parameter type payload_t = logic
) (
    input  logic                                CLK,
    input  logic                                nRST,
    input  logic [l1_cache_pkg::N_SET_BITS-1:0] sel,
    input  logic                                wen,
    input  payload_t                            wval,
    input  payload_t                            wmask,
    output payload_t                            rval
);

    payload_t mem [l1_cache_pkg::N_SETS];

    // read is combinational on the set index
    assign rval = mem[sel];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < l1_cache_pkg::N_SETS; i++) begin
                mem[i] <= '0;
            end
        end else if (wen) begin
            // new bits where mask is low, old bits elsewhere
            mem[sel] <= payload_t'((wval & ~wmask) | (mem[sel] & wmask));
        end
    end

endmodule

// ==== cache_way/cache_way.sv ====
// one cache way built from a tag array and a data array on a shared set index
`timescale 1ns/1ps

module cache_way (
    input  logic                                CLK,
    input  logic                                nRST,
    input  logic [l1_cache_pkg::N_SET_BITS-1:0] sel,
    input  l1_cache_pkg::way_cmd_t              cmd,
    output l1_cache_pkg::way_read_t             rd
);

    l1_cache_pkg::tag_entry_t tag_rval;
    l1_cache_pkg::block_t     data_rval;

    // tag entries are always written whole
    sram_array #(
        .payload_t (l1_cache_pkg::tag_entry_t)
    ) u_tag_array (
        .CLK   (CLK),
        .nRST  (nRST),
        .sel   (sel),
        .wen   (cmd.tag_wen),
        .wval  (cmd.tag),
        .wmask ('0),
        .rval  (tag_rval)
    );

    // data side honours the byte-level mask from the controller
    sram_array #(
        .payload_t (l1_cache_pkg::block_t)
    ) u_data_array (
        .CLK   (CLK),
        .nRST  (nRST),
        .sel   (sel),
        .wen   (cmd.data_wen),
        .wval  (cmd.data),
        .wmask (cmd.data_mask),
        .rval  (data_rval)
    );

    // frame as seen by the comparator
    always_comb begin
        rd.tag  = tag_rval;
        rd.data = data_rval;
    end

endmodule

// ==== cache_way/way_compare.sv ====
// way_compare: tag match across ways, hit word select and victim frame output
`timescale 1ns/1ps

module way_compare (
    input  l1_cache_pkg::way_read_t [l1_cache_pkg::ASSOC-1:0] ways,
    input  l1_cache_pkg::cache_addr_t                         req_addr,
    input  logic [l1_cache_pkg::N_WAY_BITS-1:0]               victim_way,
    output logic                                              hit,
    output logic [l1_cache_pkg::N_WAY_BITS-1:0]               hit_way,
    output l1_cache_pkg::word_t                               hit_word,
    output l1_cache_pkg::tag_entry_t                          victim_entry,
    output l1_cache_pkg::block_t                              victim_block
);

    l1_cache_pkg::block_t hit_block;

    // valid frame with matching tag
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int i = 0; i < l1_cache_pkg::ASSOC; i++) begin
            if (ways[i].tag.valid && ways[i].tag.tag == req_addr.tag) begin
                hit     = 1'b1;
                hit_way = i[l1_cache_pkg::N_WAY_BITS-1:0];
            end
        end
    end

    assign hit_block = ways[hit_way].data;
    assign hit_word  = hit_block[req_addr.blk_off];   // word within block

    // frame the controller may evict or flush
    assign victim_entry = ways[victim_way].tag;
    assign victim_block = ways[victim_way].data;

endmodule

// ==== cache_ctrl/cache_ctrl.sv ====
// cache_ctrl: clear/hit/fetch/write-back/flush FSM, LRU bits, flush counter, pass-through
`timescale 1ns/1ps

module cache_ctrl (
    input  logic                                             CLK,
    input  logic                                             nRST,
    input  logic                                             flush,
    input  l1_cache_pkg::proc_req_t                          proc_req,
    output l1_cache_pkg::proc_resp_t                         proc_resp,
    output l1_cache_pkg::mem_req_t                           mem_req,
    input  l1_cache_pkg::mem_resp_t                          mem_resp,
    output logic                                             flush_done,
    output logic [l1_cache_pkg::N_SET_BITS-1:0]              sel,
    output l1_cache_pkg::way_cmd_t [l1_cache_pkg::ASSOC-1:0] way_cmd,
    output logic [l1_cache_pkg::N_WAY_BITS-1:0]              victim_way,
    output l1_cache_pkg::cache_addr_t                        req_addr,
    input  logic                                             hit,
    input  logic [l1_cache_pkg::N_WAY_BITS-1:0]              hit_way,
    input  l1_cache_pkg::word_t                              hit_word,
    input  l1_cache_pkg::tag_entry_t                         victim_entry,
    input  l1_cache_pkg::block_t                             victim_block
);

    typedef enum logic [2:0] {CLEAR, HIT, FETCH, WB, FLUSH} state_t;

    // carries into finish once every frame has been visited
    typedef struct packed {
        logic                                finish;
        logic [l1_cache_pkg::N_SET_BITS-1:0] set_idx;
        logic [l1_cache_pkg::N_WAY_BITS-1:0] way;
    } flush_cnt_t;

    state_t                          state, next_state;
    flush_cnt_t                      flush_cnt, next_flush_cnt;
    l1_cache_pkg::cache_addr_t       saved_addr, next_saved_addr;
    l1_cache_pkg::cache_addr_t       cur_addr;
    logic                            flush_req, next_flush_req;
    logic [l1_cache_pkg::N_SETS-1:0] lru, next_lru;     // way used last, per set
    logic                            access, pass_through, access_done;

    function automatic l1_cache_pkg::word_t block_addr(
        input logic [l1_cache_pkg::N_TAG_BITS-1:0] tag,
        input logic [l1_cache_pkg::N_SET_BITS-1:0] set_idx
    );
        l1_cache_pkg::cache_addr_t a;
        a         = '0;
        a.tag     = tag;
        a.set_idx = set_idx;
        return a;
    endfunction

    assign cur_addr     = l1_cache_pkg::cache_addr_t'(proc_req.addr);
    assign access       = proc_req.ren | proc_req.wen;
    assign pass_through = access && (proc_req.addr >= l1_cache_pkg::NONCACHE_START_ADDR);
    assign access_done  = !access || (pass_through ? !mem_resp.busy : hit);

    always_comb begin
        case (state)
            HIT:       sel = cur_addr.set_idx;
            FETCH, WB: sel = saved_addr.set_idx;
            default:   sel = flush_cnt.set_idx;    // clear and flush sweeps
        endcase
    end

    assign req_addr   = (state == HIT) ? cur_addr : saved_addr;
    assign victim_way = (state == CLEAR || state == FLUSH) ? flush_cnt.way : ~lru[sel];

    // a flush pulse waits here until the sweep starts
    assign next_flush_req = (flush_req | flush) & (state != FLUSH);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state      <= CLEAR;
            flush_cnt  <= '0;
            saved_addr <= '0;
            flush_req  <= 1'b0;
            lru        <= '0;
        end else begin
            state      <= next_state;
            flush_cnt  <= next_flush_cnt;
            saved_addr <= next_saved_addr;
            flush_req  <= next_flush_req;
            lru        <= next_lru;
        end
    end

    always_comb begin
        next_state      = state;
        next_flush_cnt  = flush_cnt;
        next_saved_addr = saved_addr;
        next_lru        = lru;
        proc_resp       = '0;
        proc_resp.busy  = 1'b1;
        mem_req         = '0;
        mem_req.byte_en = '1;    // whole blocks unless passing through
        way_cmd         = '0;
        flush_done      = 1'b0;

        case (state)
            CLEAR: begin
                if (flush_cnt.finish) begin
                    next_flush_cnt = '0;
                    next_state     = HIT;
                end else begin
                    way_cmd[flush_cnt.way].tag_wen = 1'b1;   // zero tag entry
                    next_flush_cnt = flush_cnt_t'(flush_cnt + 1'b1);
                end
            end
            HIT: begin
                if (pass_through) begin
                    mem_req.ren      = proc_req.ren;
                    mem_req.wen      = proc_req.wen;
                    mem_req.addr     = proc_req.addr;
                    mem_req.byte_en  = proc_req.byte_en;
                    mem_req.wdata[0] = proc_req.wdata;
                    proc_resp.busy   = mem_resp.busy;
                    proc_resp.rdata  = mem_resp.rdata[0];
                end else if (access && hit) begin
                    proc_resp.busy             = 1'b0;
                    proc_resp.rdata            = hit_word;
                    next_lru[cur_addr.set_idx] = hit_way;
                    if (proc_req.wen) begin
                        way_cmd[hit_way].tag_wen   = 1'b1;
                        way_cmd[hit_way].tag       = '{valid: 1'b1, dirty: 1'b1, tag: cur_addr.tag};
                        way_cmd[hit_way].data_wen  = 1'b1;
                        way_cmd[hit_way].data      = {l1_cache_pkg::BLOCK_SIZE{proc_req.wdata}};
                        way_cmd[hit_way].data_mask = '1;
                        // open only the enabled bytes of the addressed word
                        for (int b = 0; b < 4; b++) begin
                            way_cmd[hit_way].data_mask[cur_addr.blk_off][8*b +: 8] =
                                {8{~proc_req.byte_en[b]}};
                        end
                    end
                end else if (access) begin
                    next_saved_addr = cur_addr;
                    next_state = (victim_entry.valid && victim_entry.dirty) ? WB : FETCH;
                end
                if ((flush || flush_req) && access_done) begin
                    next_state = FLUSH;
                end
            end
            FETCH: begin
                mem_req.ren  = 1'b1;
                mem_req.addr = block_addr(saved_addr.tag, saved_addr.set_idx);
                if (!mem_resp.busy) begin
                    way_cmd[victim_way].tag_wen  = 1'b1;
                    way_cmd[victim_way].tag      = '{valid: 1'b1, dirty: 1'b0, tag: saved_addr.tag};
                    way_cmd[victim_way].data_wen = 1'b1;
                    way_cmd[victim_way].data     = mem_resp.rdata;
                    next_state = HIT;    // held request now hits
                end
            end
            WB: begin
                mem_req.wen   = 1'b1;
                mem_req.addr  = block_addr(victim_entry.tag, saved_addr.set_idx);
                mem_req.wdata = victim_block;
                if (!mem_resp.busy) begin
                    way_cmd[victim_way].tag_wen = 1'b1;   // invalid until refilled
                    next_state = FETCH;
                end
            end
            FLUSH: begin
                if (flush_cnt.finish) begin
                    flush_done     = 1'b1;
                    next_flush_cnt = '0;
                    next_state     = HIT;
                end else if (victim_entry.valid && victim_entry.dirty) begin
                    mem_req.wen   = 1'b1;
                    mem_req.addr  = block_addr(victim_entry.tag, flush_cnt.set_idx);
                    mem_req.wdata = victim_block;
                    if (!mem_resp.busy) begin
                        way_cmd[flush_cnt.way].tag_wen = 1'b1;
                        next_flush_cnt = flush_cnt_t'(flush_cnt + 1'b1);
                    end
                end else begin
                    way_cmd[flush_cnt.way].tag_wen = 1'b1;   // clean frame, just drop it
                    next_flush_cnt = flush_cnt_t'(flush_cnt + 1'b1);
                end
            end
            default: next_state = CLEAR;
        endcase
    end

endmodule

// ==== source/l1_cache.sv ====
// l1_cache: top level joining controller, two cache ways and the way comparator
`timescale 1ns/1ps

module l1_cache (
    input  logic                     CLK,
    input  logic                     nRST,
    input  logic                     flush,
    input  l1_cache_pkg::proc_req_t  proc_req,
    output l1_cache_pkg::proc_resp_t proc_resp,
    output l1_cache_pkg::mem_req_t   mem_req,
    input  l1_cache_pkg::mem_resp_t  mem_resp,
    output logic                     flush_done
);

    logic [l1_cache_pkg::N_SET_BITS-1:0]              sel;
    l1_cache_pkg::way_cmd_t [l1_cache_pkg::ASSOC-1:0]  way_cmd;
    l1_cache_pkg::way_read_t [l1_cache_pkg::ASSOC-1:0] way_rd;
    logic [l1_cache_pkg::N_WAY_BITS-1:0]              victim_way;
    l1_cache_pkg::cache_addr_t                        req_addr;
    logic                                             hit;
    logic [l1_cache_pkg::N_WAY_BITS-1:0]              hit_way;
    l1_cache_pkg::word_t                              hit_word;
    l1_cache_pkg::tag_entry_t                         victim_entry;
    l1_cache_pkg::block_t                             victim_block;

    cache_ctrl u_cache_ctrl (
        .CLK          (CLK),
        .nRST         (nRST),
        .flush        (flush),
        .proc_req     (proc_req),
        .proc_resp    (proc_resp),
        .mem_req      (mem_req),
        .mem_resp     (mem_resp),
        .flush_done   (flush_done),
        .sel          (sel),
        .way_cmd      (way_cmd),
        .victim_way   (victim_way),
        .req_addr     (req_addr),
        .hit          (hit),
        .hit_way      (hit_way),
        .hit_word     (hit_word),
        .victim_entry (victim_entry),
        .victim_block (victim_block)
    );

    // identical ways on a common set index
    for (genvar g = 0; g < l1_cache_pkg::ASSOC; g++) begin : g_way
        cache_way u_cache_way (
            .CLK  (CLK),
            .nRST (nRST),
            .sel  (sel),
            .cmd  (way_cmd[g]),
            .rd   (way_rd[g])
        );
    end

    way_compare u_way_compare (
        .ways         (way_rd),
        .req_addr     (req_addr),
        .victim_way   (victim_way),
        .hit          (hit),
        .hit_way      (hit_way),
        .hit_word     (hit_word),
        .victim_entry (victim_entry),
        .victim_block (victim_block)
    );

endmodule

// ==== test/l1_cache_properties.sv ====
// bound assertions on memory request exclusivity, back-pressure hold and the flush_done pulse
`timescale 1ns/1ps

module l1_cache_properties (
    input logic                    CLK,
    input logic                    nRST,
    input l1_cache_pkg::mem_req_t  mem_req,
    input l1_cache_pkg::mem_resp_t mem_resp,
    input logic                    flush_done
);

    int n_failed = 0;    // failed assertions so far

    // one direction at a time on the memory side
    assert property (@(posedge CLK) disable iff (!nRST) !(mem_req.ren && mem_req.wen))
        else begin
            n_failed++;
            $error("memory read and write requested together");
        end

    assert property (@(posedge CLK) disable iff (!nRST) flush_done |=> !flush_done)
        else begin
            n_failed++;
            $error("flush_done held longer than one cycle");
        end

    // a stalled memory request stays put until memory takes it
    assert property (@(posedge CLK) disable iff (!nRST)
                     (mem_req.ren || mem_req.wen) && mem_resp.busy |=> $stable(mem_req))
        else begin
            n_failed++;
            $error("memory request changed while memory was busy");
        end

endmodule

bind cache_ctrl l1_cache_properties u_properties (
    .CLK        (CLK),
    .nRST       (nRST),
    .mem_req    (mem_req),
    .mem_resp   (mem_resp),
    .flush_done (flush_done)
);

// ==== test/l1_cache_checker.sv ====
// l1_cache_checker: compares read data, miss behaviour and flush pulses against the trace
`timescale 1ns/1ps

module l1_cache_checker (
    input  logic                     CLK,
    input  logic                     nRST,
    input  l1_cache_pkg::proc_req_t  proc_req,
    input  l1_cache_pkg::proc_resp_t proc_resp,
    input  l1_cache_pkg::mem_req_t   mem_req,
    input  logic                     flush_done,
    input  logic                     is_read,
    input  l1_cache_pkg::word_t      exp_rdata,
    input  logic                     exp_miss,
    input  int                       cur_line,
    input  int                       exp_flushes,
    input  logic                     end_of_test,
    output int                       mismatches,
    output int                       other_errors
);

    logic mem_seen;      // memory request during the current access
    int   flush_pulses;
    logic seen_now;

    initial begin
        mismatches   = 0;
        other_errors = 0;
        flush_pulses = 0;
        mem_seen     = 1'b0;
    end

    // sampled mid-cycle where everything is settled
    always @(negedge CLK) begin
        if (nRST) begin
            if (flush_done) begin
                flush_pulses = flush_pulses + 1;
            end
            if (proc_req.ren || proc_req.wen) begin
                seen_now = mem_seen || mem_req.ren || mem_req.wen;
                mem_seen = seen_now;
                if (!proc_resp.busy) begin
                    if (is_read && proc_resp.rdata !== exp_rdata) begin
                        mismatches++;
                        $display("MISMATCH line %0d read data: expected %h, actual %h",
                                 cur_line, exp_rdata, proc_resp.rdata);
                    end
                    if (seen_now !== exp_miss) begin
                        mismatches++;
                        $display("MISMATCH line %0d memory request: expected %0d, actual %0d",
                                 cur_line, exp_miss, seen_now);
                    end
                    mem_seen = 1'b0;
                end
            end
        end
    end

    always @(posedge end_of_test) begin
        if (flush_pulses != exp_flushes) begin
            other_errors++;
            $display("flush_done pulsed %0d times but %0d flushes were requested",
                     flush_pulses, exp_flushes);
        end
    end

endmodule

// ==== test/l1_cache_tb.sv ====
// testbench top with clock, reset, LFSR, memory model, trace reader, stimulus, watchdog and DUT
`timescale 1ns/1ps

module l1_cache_tb;

    logic                     CLK;
    logic                     nRST;
    logic                     flush;
    l1_cache_pkg::proc_req_t  proc_req;
    l1_cache_pkg::proc_resp_t proc_resp;
    l1_cache_pkg::mem_req_t   mem_req;
    l1_cache_pkg::mem_resp_t  mem_resp;
    logic                     flush_done;

    // trace contents
    byte                 op_kind [$];
    l1_cache_pkg::word_t op_addr [$];
    l1_cache_pkg::word_t op_wdata [$];
    logic [3:0]          op_be [$];
    l1_cache_pkg::word_t op_exp [$];
    logic                op_miss [$];
    int                  op_line [$];
    int                  n_ops;

    // expected values handed to the checker
    logic                is_read;
    l1_cache_pkg::word_t exp_rdata;
    logic                exp_miss;
    int                  cur_line;
    int                  exp_flushes;
    logic                end_of_test;
    int                  mismatches;
    int                  other_errors;
    int                  assert_fails;

    // memory model state
    l1_cache_pkg::word_t mem_model [l1_cache_pkg::word_t];
    logic [31:0]         lfsr_state;
    logic                pending;
    logic [1:0]          wait_left;

    l1_cache u_l1_cache (
        .CLK        (CLK),
        .nRST       (nRST),
        .flush      (flush),
        .proc_req   (proc_req),
        .proc_resp  (proc_resp),
        .mem_req    (mem_req),
        .mem_resp   (mem_resp),
        .flush_done (flush_done)
    );

    l1_cache_checker u_checker (
        .CLK          (CLK),
        .nRST         (nRST),
        .proc_req     (proc_req),
        .proc_resp    (proc_resp),
        .mem_req      (mem_req),
        .flush_done   (flush_done),
        .is_read      (is_read),
        .exp_rdata    (exp_rdata),
        .exp_miss     (exp_miss),
        .cur_line     (cur_line),
        .exp_flushes  (exp_flushes),
        .end_of_test  (end_of_test),
        .mismatches   (mismatches),
        .other_errors (other_errors)
    );

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    // galois lfsr stepped once per bit
    function automatic logic lfsr_step();
        logic lsb;
        lsb        = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (lsb) begin
            lfsr_state = lfsr_state ^ 32'hA300_0000;
        end
        return lsb;
    endfunction

    function automatic l1_cache_pkg::word_t mem_read_word(input l1_cache_pkg::word_t a);
        if (mem_model.exists(a)) begin
            return mem_model[a];
        end
        return a ^ 32'h5A5A_0000;    // never written
    endfunction

    task automatic mem_serve();
        l1_cache_pkg::word_t base;
        l1_cache_pkg::word_t w;
        l1_cache_pkg::block_t blk;
        int n_words;
        base    = mem_req.addr & ~32'h3;
        n_words = (mem_req.addr >= l1_cache_pkg::NONCACHE_START_ADDR) ? 1 : 2;
        blk     = '0;
        for (int i = 0; i < n_words; i++) begin
            w = mem_read_word(base + 4 * i);
            if (mem_req.wen) begin
                for (int b = 0; b < 4; b++) begin
                    if (mem_req.byte_en[b]) begin
                        w[8*b +: 8] = mem_req.wdata[i][8*b +: 8];
                    end
                end
                mem_model[base + 4 * i] = w;
            end
            blk[i] = w;
        end
        mem_resp.rdata <= blk;
    endtask

    // memory answers after 0 to 3 extra cycles
    always @(posedge CLK) begin
        if (!nRST) begin
            mem_resp.busy <= 1'b1;
            pending = 1'b0;
        end else begin
            mem_resp.busy <= 1'b1;
            if ((mem_req.ren || mem_req.wen) && mem_resp.busy) begin
                if (!pending) begin
                    pending      = 1'b1;
                    wait_left[1] = lfsr_step();
                    wait_left[0] = lfsr_step();
                end
                if (wait_left == 2'd0) begin
                    pending = 1'b0;
                    mem_serve();
                    mem_resp.busy <= 1'b0;
                end else begin
                    wait_left = wait_left - 2'd1;
                end
            end
        end
    end

    task automatic load_trace();
        int fd;
        int n;
        int line_no;
        string line;
        byte k;
        logic [31:0] a;
        logic [31:0] d;
        logic [3:0] be;
        logic [31:0] e;
        logic m;
        fd = $fopen("test/cache_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open the trace file test/cache_trace.txt");
            return;
        end
        line_no = 0;
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            line_no++;
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%c %h %h %b %h %d", k, a, d, be, e, m);
            if (n == 6) begin
                op_kind.push_back(k);
                op_addr.push_back(a);
                op_wdata.push_back(d);
                op_be.push_back(be);
                op_exp.push_back(e);
                op_miss.push_back(m);
                op_line.push_back(line_no);
            end
        end
        $fclose(fd);
    endtask

    initial begin
        proc_req       = '0;
        flush          = 1'b0;
        mem_resp       = '0;
        mem_resp.busy  = 1'b1;
        nRST           = 1'b0;
        is_read        = 1'b0;
        exp_rdata      = '0;
        exp_miss       = 1'b0;
        cur_line       = 0;
        exp_flushes    = 0;
        end_of_test    = 1'b0;
        assert_fails   = 0;
        lfsr_state     = 32'hb62a2480;
        pending        = 1'b0;
        wait_left      = '0;
        n_ops          = 0;
        load_trace();
        n_ops = op_kind.size();
        repeat (16) @(posedge CLK);
        nRST <= 1'b1;
        for (int i = 0; i < op_kind.size(); i++) begin
            @(posedge CLK);
            cur_line <= op_line[i];
            if (op_kind[i] == "F") begin
                exp_flushes <= exp_flushes + 1;
                flush <= 1'b1;
                @(posedge CLK);
                flush <= 1'b0;
                @(negedge CLK);
                while (!flush_done) @(negedge CLK);
            end else begin
                is_read          <= (op_kind[i] == "R");
                exp_rdata        <= op_exp[i];
                exp_miss         <= op_miss[i];
                proc_req.ren     <= (op_kind[i] == "R");
                proc_req.wen     <= (op_kind[i] == "W");
                proc_req.addr    <= op_addr[i];
                proc_req.wdata   <= op_wdata[i];
                proc_req.byte_en <= op_be[i];
                @(negedge CLK);
                while (proc_resp.busy) @(negedge CLK);
                @(posedge CLK);
                proc_req <= '0;
            end
        end
        repeat (2) @(posedge CLK);
        end_of_test <= 1'b1;
        @(negedge CLK);
        assert_fails = u_l1_cache.u_cache_ctrl.u_properties.n_failed;
        $display("errors: mismatches %0d, other %0d, assertions %0d",
                 mismatches, other_errors, assert_fails);
        if (mismatches == 0 && other_errors == 0 && assert_fails == 0 && n_ops > 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // watchdog sized from the trace length
    initial begin
        wait (n_ops > 0);
        repeat (300 * n_ops + 100) @(posedge CLK);
        $display("timeout: the DUT did not finish the trace in time");
        $display("errors: mismatches %0d, other %0d, assertions %0d", mismatches,
                 other_errors + 1, u_l1_cache.u_cache_ctrl.u_properties.n_failed);
        $display("Testbench failed");
        $finish;
    end

endmodule

// ==== test/cache_trace.txt ====
# kind addr wdata byte_en(bin) expected_rdata(hex) expected_mem_request(0/1)
# kind R read, W write, F flush; rdata is ignored on W and F
R 00000100 00000000 1111 5a5a0100 1
W 00000104 aabbccdd 0011 00000000 0
R 00000104 00000000 1111 5a5accdd 0
R 00000100 00000000 1111 5a5a0100 0
R 00000180 00000000 1111 5a5a0180 1
W 00000180 11223344 1111 00000000 0
R 00000200 00000000 1111 5a5a0200 1
R 00000104 00000000 1111 5a5accdd 1
R 00000180 00000000 1111 11223344 1
W 00000208 0badf00d 1111 00000000 1
W 0000020c 12345678 1100 00000000 0
F 00000000 00000000 0000 00000000 0
R 00000208 00000000 1111 0badf00d 1
R 0000020c 00000000 1111 1234020c 0
R 00000100 00000000 1111 5a5a0100 1
R f0000010 00000000 1111 aa5a0010 1
W f0000010 cafebabe 0101 00000000 1
R f0000010 00000000 1111 aafe00be 1
R f0000014 00000000 1111 aa5a0014 1
W 00000308 55667788 1111 00000000 1
F 00000000 00000000 0000 00000000 0
R 00000308 00000000 1111 55667788 1
R 0000030c 00000000 1111 5a5a030c 0

// ==== sim.f ====
common/l1_cache_pkg.sv
source/sram_array.sv
cache_way/cache_way.sv
cache_way/way_compare.sv
cache_ctrl/cache_ctrl.sv
source/l1_cache.sv
test/l1_cache_properties.sv
test/l1_cache_checker.sv
test/l1_cache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the cache testbench with Verilator, run from the project root
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module l1_cache_tb \
    -f sim.f -o l1_cache_sim \
    && ./obj_dir/l1_cache_sim > sim.log 2>&1 \
    ; cat sim.log 2>/dev/null \
    ; grep -q "Testbench passed" sim.log \
    && echo "simulation PASS" \
    || { echo "simulation FAIL"; exit 1; }
